//--- src/noc_pkg.sv
package noc_pkg;

        // router ports: four mesh directions plus the local core
        localparam int NUM_PORTS = 5;

        // width of one next-hop or source code
        localparam int PORT_CODE_W = 3;

        // packed widths of the per-port bundles
        localparam int CODES_W  = NUM_PORTS * PORT_CODE_W;
        localparam int MATRIX_W = NUM_PORTS * NUM_PORTS;

        typedef logic [PORT_CODE_W-1:0] port_code_t;

        // bit i of every per-port vector belongs to code i
        localparam port_code_t PORT_N = 3'd0;
        localparam port_code_t PORT_S = 3'd1;
        localparam port_code_t PORT_W = 3'd2;
        localparam port_code_t PORT_E = 3'd3;
        localparam port_code_t PORT_L = 3'd4;

        // one-hot port vector to its port code, zero when empty
        function automatic port_code_t onehot_to_code(
                input logic [NUM_PORTS-1:0] onehot
        );
                port_code_t code;
                code = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        if (onehot[i]) begin
                                code = code | port_code_t'(i);
                        end
                end
                return code;
        endfunction

endpackage

//--- src/route_decode.sv
`timescale 1ns/1ps

module route_decode (
        input  logic [noc_pkg::NUM_PORTS-1:0] req_i,
        input  logic [noc_pkg::NUM_PORTS-1:0] ack_i,
        input  logic [noc_pkg::CODES_W-1:0]   dest_i,
        output logic [noc_pkg::MATRIX_W-1:0]  desire_o
);

        localparam int NP = noc_pkg::NUM_PORTS;
        localparam int CW = noc_pkg::PORT_CODE_W;

        // a request counts only until its ack comes back
        logic [NP-1:0] pending;

        noc_pkg::port_code_t dest_code [NP];

        assign pending = req_i & ~ack_i;

        genvar i;
        genvar o;

        generate
                for (i = 0; i < NP; i++) begin : g_split
                        assign dest_code[i] = dest_i[i*CW +: CW];
                end

                // row o lists the inputs that want output o
                for (o = 0; o < NP; o++) begin : g_row
                        for (i = 0; i < NP; i++) begin : g_col
                                if (o == i) begin : g_uturn
                                        // no path back out of the same port
                                        assign desire_o[o*NP + i] = 1'b0;
                                end else begin : g_cmp
                                        assign desire_o[o*NP + i] =
                                                pending[i] &&
                                                (dest_code[i] == noc_pkg::port_code_t'(o));
                                end
                        end
                end
        endgenerate

endmodule

//--- src/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
        input  logic                          clk,
        input  logic                          reset_i,
        input  logic [noc_pkg::NUM_PORTS-1:0] desire_i,
        input  logic                          credit_i,
        output logic [noc_pkg::NUM_PORTS-1:0] grant_o
);

        localparam int NP = noc_pkg::NUM_PORTS;

        // input that won this output most recently
        noc_pkg::port_code_t last_q;

        // first input looked at in the rotation
        noc_pkg::port_code_t start;

        logic [NP-1:0] winner;

        assign start = (last_q == noc_pkg::PORT_L) ? noc_pkg::PORT_N
                                                   : noc_pkg::port_code_t'(last_q + 1);

        // walk the ring once from start, first desiring input wins
        always_comb begin
                noc_pkg::port_code_t idx;
                winner = '0;
                idx    = start;
                for (int k = 0; k < NP; k++) begin
                        if (desire_i[idx] && (winner == '0)) begin
                                winner[idx] = 1'b1;
                        end
                        if (idx == noc_pkg::PORT_L) begin
                                idx = noc_pkg::PORT_N;
                        end else begin
                                idx = noc_pkg::port_code_t'(idx + 1);
                        end
                end
        end

        // no credit downstream, no grant
        assign grant_o = credit_i ? winner : '0;

        // pointer moves only when something was actually granted
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        last_q <= noc_pkg::PORT_L;
                end else if (|grant_o) begin
                        last_q <= noc_pkg::onehot_to_code(grant_o);
                end
        end

endmodule

//--- src/grant_result.sv
`timescale 1ns/1ps

module grant_result #(
        parameter int FLIT_W = 16
) (
        input  logic                                 clk,
        input  logic                                 reset_i,
        input  logic [noc_pkg::MATRIX_W-1:0]         grant_i,
        input  logic [noc_pkg::NUM_PORTS-1:0]        req_i,
        input  logic [noc_pkg::NUM_PORTS*FLIT_W-1:0] flit_i,
        output logic [noc_pkg::NUM_PORTS-1:0]        ack_o,
        output logic [noc_pkg::NUM_PORTS-1:0]        out_valid_o,
        output logic [noc_pkg::NUM_PORTS*FLIT_W-1:0] out_flit_o,
        output logic [noc_pkg::CODES_W-1:0]          out_src_o
);

        localparam int NP = noc_pkg::NUM_PORTS;
        localparam int CW = noc_pkg::PORT_CODE_W;

        // one-hot grant per output, indexed by input
        logic [NP-1:0] row [NP];

        // flit picked for each output
        logic [FLIT_W-1:0] sel_flit [NP];

        // inputs granted on any output this cycle
        logic [NP-1:0] granted;

        genvar o;

        generate
                for (o = 0; o < NP; o++) begin : g_row
                        assign row[o] = grant_i[o*NP +: NP];
                end
        endgenerate

        // and-or crossbar, rows are one-hot
        always_comb begin
                granted = '0;
                for (int p = 0; p < NP; p++) begin
                        sel_flit[p] = '0;
                        for (int i = 0; i < NP; i++) begin
                                sel_flit[p] = sel_flit[p] |
                                        (flit_i[i*FLIT_W +: FLIT_W] & {FLIT_W{row[p][i]}});
                                granted[i] = granted[i] | row[p][i];
                        end
                end
        end

        // four-phase ack: set on grant, held until req is seen low
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        ack_o       <= '0;
                        out_valid_o <= '0;
                end else begin
                        ack_o <= granted | (ack_o & req_i);
                        for (int p = 0; p < NP; p++) begin
                                out_valid_o[p] <= |row[p];
                        end
                end
        end

        // output payload, loaded only with a transfer
        always_ff @(posedge clk) begin
                for (int p = 0; p < NP; p++) begin
                        if (|row[p]) begin
                                out_flit_o[p*FLIT_W +: FLIT_W] <= sel_flit[p];
                                out_src_o[p*CW +: CW]          <=
                                        noc_pkg::onehot_to_code(row[p]);
                        end
                end
        end

endmodule

//--- src/xbar_switch.sv
`timescale 1ns/1ps

module xbar_switch #(
        parameter int FLIT_W = 16
) (
        input  logic                                 clk,
        input  logic                                 reset_i,
        input  logic [noc_pkg::NUM_PORTS-1:0]        req_i,
        input  logic [noc_pkg::CODES_W-1:0]          dest_i,
        input  logic [noc_pkg::NUM_PORTS*FLIT_W-1:0] flit_i,
        input  logic [noc_pkg::NUM_PORTS-1:0]        credit_i,
        output logic [noc_pkg::NUM_PORTS-1:0]        ack_o,
        output logic [noc_pkg::NUM_PORTS-1:0]        out_valid_o,
        output logic [noc_pkg::NUM_PORTS*FLIT_W-1:0] out_flit_o,
        output logic [noc_pkg::CODES_W-1:0]          out_src_o
);

        localparam int NP = noc_pkg::NUM_PORTS;

        // output-major matrices, bit o*NP+i is input i toward output o
        logic [noc_pkg::MATRIX_W-1:0] desire;
        logic [noc_pkg::MATRIX_W-1:0] grant;

        route_decode decode0 (
                .req_i    (req_i),
                .ack_i    (ack_o),
                .dest_i   (dest_i),
                .desire_o (desire)
        );

        // one arbiter per output port
        genvar o;

        generate
                for (o = 0; o < NP; o++) begin : g_arb
                        rr_arbiter arb (
                                .clk      (clk),
                                .reset_i  (reset_i),
                                .desire_i (desire[o*NP +: NP]),
                                .credit_i (credit_i[o]),
                                .grant_o  (grant[o*NP +: NP])
                        );
                end
        endgenerate

        grant_result #(
                .FLIT_W (FLIT_W)
        ) result0 (
                .clk         (clk),
                .reset_i     (reset_i),
                .grant_i     (grant),
                .req_i       (req_i),
                .flit_i      (flit_i),
                .ack_o       (ack_o),
                .out_valid_o (out_valid_o),
                .out_flit_o  (out_flit_o),
                .out_src_o   (out_src_o)
        );

endmodule

//--- verif/xbar_switch_sva.sv
`timescale 1ns/1ps

module xbar_switch_sva (
        input logic                          clk,
        input logic                          reset_i,
        input logic [noc_pkg::NUM_PORTS-1:0] req_i,
        input logic [noc_pkg::NUM_PORTS-1:0] ack_i,
        input logic [noc_pkg::NUM_PORTS-1:0] valid_i,
        input logic [noc_pkg::NUM_PORTS-1:0] credit_i,
        input logic [noc_pkg::MATRIX_W-1:0]  grant_i
);

        localparam int NP = noc_pkg::NUM_PORTS;

        // grant matrix turned input-major, one column per input
        logic [noc_pkg::MATRIX_W-1:0] col;

        genvar p;
        genvar o;

        generate
                for (p = 0; p < NP; p++) begin : g_port
                        for (o = 0; o < NP; o++) begin : g_col
                                assign col[p*NP + o] = grant_i[o*NP + p];
                        end

                        a_ack_needs_req : assert property (@(posedge clk) disable iff (reset_i)
                                $rose(ack_i[p]) |-> $past(req_i[p]))
                                else $error("ack %0d rose without a request", p);

                        a_ack_holds : assert property (@(posedge clk) disable iff (reset_i)
                                (ack_i[p] && req_i[p]) |=> ack_i[p])
                                else $error("ack %0d dropped while req was still high", p);

                        // p taken as an output here
                        a_valid_credit : assert property (@(posedge clk) disable iff (reset_i)
                                valid_i[p] |-> $past(credit_i[p]))
                                else $error("output %0d sent a flit without credit", p);

                        a_one_grant : assert property (@(posedge clk) disable iff (reset_i)
                                $onehot0(col[p*NP +: NP]))
                                else $error("input %0d granted on more than one output", p);
                end
        endgenerate

endmodule

bind xbar_switch xbar_switch_sva sva0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .ack_i    (ack_o),
        .valid_i  (out_valid_o),
        .credit_i (credit_i),
        .grant_i  (grant)
);

//--- verif/xbar_switch_checker.sv
`timescale 1ns/1ps

module xbar_switch_checker #(
        parameter int FLIT_W = 16
) (
        input logic                                 clk,
        input logic                                 reset_i,
        input logic [noc_pkg::NUM_PORTS-1:0]        req_i,
        input logic [noc_pkg::CODES_W-1:0]          dest_i,
        input logic [noc_pkg::NUM_PORTS-1:0]        credit_i,
        input logic [noc_pkg::NUM_PORTS-1:0]        ack_i,
        input logic [noc_pkg::NUM_PORTS-1:0]        out_valid_i,
        input logic [noc_pkg::NUM_PORTS*FLIT_W-1:0] out_flit_i,
        input logic [noc_pkg::CODES_W-1:0]          out_src_i
);

        localparam int NP = noc_pkg::NUM_PORTS;
        localparam int CW = noc_pkg::PORT_CODE_W;

        int total_errors = 0;
        int test_errors  = 0;
        int tests_run    = 0;
        int tests_failed = 0;
        int moved        = 0;

        // reference round-robin model
        bit                live = 1'b0;
        int                last [NP];
        logic [NP-1:0]     exp_ack;
        logic [NP-1:0]     exp_valid;
        int                exp_src [NP];

        // transfers announced by the testbench, still in flight
        int                e_src [$];
        int                e_port [$];
        logic [FLIT_W-1:0] e_flit [$];

        task automatic expect_flit(input int src, input int port, input logic [FLIT_W-1:0] value);
                e_src.push_back(src);
                e_port.push_back(port);
                e_flit.push_back(value);
        endtask

        task automatic note_error();
                total_errors++;
                test_errors++;
        endtask

        task automatic flag_value(input string name, input string exp, input string got);
                $display("[ERROR] %s expected %s got %s at %0t", name, exp, got, $time);
                note_error();
        endtask

        task automatic end_test(input int id);
                if (e_src.size() != 0) begin
                        $display("test %0d: %0d flits never reached an output", id, e_src.size());
                        note_error();
                        e_src.delete();
                        e_port.delete();
                        e_flit.delete();
                end
                tests_run++;
                if (test_errors == 0) begin
                        $display("test %0d ok, %0d transfers", id, moved);
                end else begin
                        tests_failed++;
                        $display("test %0d FAILED with %0d errors", id, test_errors);
                end
                test_errors = 0;
                moved       = 0;
        endtask

        task automatic report_counts();
                $display("%0d tests run, %0d failed, %0d errors",
                         tests_run, tests_failed, total_errors);
        endtask

        // pair a delivered flit with the oldest announced one of its source
        task automatic match_delivery(input int o);
                int src;
                int hit;
                src = int'(out_src_i[o*CW +: CW]);
                hit = -1;
                for (int k = 0; k < e_src.size(); k++) begin
                        if (hit < 0 && e_src[k] == src) begin
                                hit = k;
                        end
                end
                if (hit < 0) begin
                        $display("unexpected transfer from input %0d on output %0d at %0t",
                                 src, o, $time);
                        note_error();
                end else begin
                        if (e_port[hit] != o) begin
                                flag_value($sformatf("out_valid_o port of input %0d", src),
                                           $sformatf("%h", e_port[hit]), $sformatf("%h", o));
                        end
                        if (out_flit_i[o*FLIT_W +: FLIT_W] !== e_flit[hit]) begin
                                flag_value($sformatf("out_flit_o[%0d]", o),
                                           $sformatf("%h", e_flit[hit]),
                                           $sformatf("%h", out_flit_i[o*FLIT_W +: FLIT_W]));
                        end
                        e_src.delete(hit);
                        e_port.delete(hit);
                        e_flit.delete(hit);
                        moved++;
                end
        endtask

        // inputs are stable at the rising edge, predict what it does
        always @(posedge clk) begin
                logic [NP-1:0] pend;
                logic [NP-1:0] took;
                int            idx;
                int            win;
                if (reset_i) begin
                        live      = 1'b1;
                        exp_ack   = '0;
                        exp_valid = '0;
                        for (int o = 0; o < NP; o++) begin
                                last[o] = int'(noc_pkg::PORT_L);
                        end
                end else if (live) begin
                        pend      = req_i & ~exp_ack;
                        took      = '0;
                        exp_valid = '0;
                        for (int o = 0; o < NP; o++) begin
                                win = -1;
                                for (int k = 1; k <= NP; k++) begin
                                        idx = (last[o] + k) % NP;
                                        if (win < 0 && credit_i[o] && idx != o && pend[idx] &&
                                            int'(dest_i[idx*CW +: CW]) == o) begin
                                                win = idx;
                                        end
                                end
                                if (win >= 0) begin
                                        exp_valid[o] = 1'b1;
                                        exp_src[o]   = win;
                                        took[win]    = 1'b1;
                                        last[o]      = win;
                                end
                        end
                        exp_ack = took | (exp_ack & req_i);
                end
        end

        // outputs settled since the rising edge
        always @(negedge clk) begin
                if (live) begin
                        if (ack_i !== exp_ack) begin
                                flag_value("ack_o", $sformatf("%h", exp_ack),
                                           $sformatf("%h", ack_i));
                        end
                        if (out_valid_i !== exp_valid) begin
                                flag_value("out_valid_o", $sformatf("%h", exp_valid),
                                           $sformatf("%h", out_valid_i));
                        end
                        for (int o = 0; o < NP; o++) begin
                                if (out_valid_i[o] === 1'b1) begin
                                        if (exp_valid[o] && out_src_i[o*CW +: CW] !==
                                            noc_pkg::port_code_t'(exp_src[o])) begin
                                                flag_value($sformatf("out_src_o[%0d]", o),
                                                           $sformatf("%h", exp_src[o]),
                                                           $sformatf("%h", out_src_i[o*CW +: CW]));
                                        end
                                        match_delivery(o);
                                end
                        end
                end
        end

endmodule

//--- verif/xbar_switch_tb.sv
`timescale 1ns/1ps

module xbar_switch_tb;

        localparam int FLIT_W = 16;
        localparam int NP     = noc_pkg::NUM_PORTS;
        localparam int CW     = noc_pkg::PORT_CODE_W;

        logic                 clk;
        logic                 reset_i;
        logic [NP-1:0]        req;
        logic [NP*CW-1:0]     dest;
        logic [NP*FLIT_W-1:0] flit;
        logic [NP-1:0]        credit;
        logic [NP-1:0]        ack;
        logic [NP-1:0]        out_valid;
        logic [NP*FLIT_W-1:0] out_flit;
        logic [NP*CW-1:0]     out_src;

        // one entry per transaction line of the data file
        int                t_id [$];
        int                t_in [$];
        int                t_dest [$];
        logic [FLIT_W-1:0] t_flit [$];
        int                t_exp [$];
        int                t_hold [$];

        logic [31:0] lcg_state   = 32'h3d9c;
        int          cycles      = 0;
        int          cycle_limit = 0;
        bit          vectors_ok  = 1'b0;

        xbar_switch #(
                .FLIT_W (FLIT_W)
        ) dut0 (
                .clk         (clk),
                .reset_i     (reset_i),
                .req_i       (req),
                .dest_i      (dest),
                .flit_i      (flit),
                .credit_i    (credit),
                .ack_o       (ack),
                .out_valid_o (out_valid),
                .out_flit_o  (out_flit),
                .out_src_o   (out_src)
        );

        xbar_switch_checker #(
                .FLIT_W (FLIT_W)
        ) chk0 (
                .clk         (clk),
                .reset_i     (reset_i),
                .req_i       (req),
                .dest_i      (dest),
                .credit_i    (credit),
                .ack_i       (ack),
                .out_valid_i (out_valid),
                .out_flit_i  (out_flit),
                .out_src_i   (out_src)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic int next_rand();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return int'({17'd0, lcg_state[30:16]});
        endfunction

        task automatic load_vectors();
                int                fd;
                int                n;
                int                id;
                int                inp;
                int                dst;
                int                ex;
                int                hold;
                logic [FLIT_W-1:0] fv;
                string             line;
                fd = $fopen("verif/xbar_switch_input.txt", "r");
                if (fd == 0) begin
                        $display("could not open the test vector file");
                        return;
                end
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        // comment and blank lines do not scan to six fields
                        if (n > 0 && $sscanf(line, "%d %d %d %h %d %d",
                                             id, inp, dst, fv, ex, hold) == 6) begin
                                t_id.push_back(id);
                                t_in.push_back(inp);
                                t_dest.push_back(dst);
                                t_flit.push_back(fv);
                                t_exp.push_back(ex);
                                t_hold.push_back(hold);
                        end
                end
                $fclose(fd);
                vectors_ok = (t_id.size() > 0);
                if (!vectors_ok) begin
                        $display("the test vector file holds no transactions");
                end
        endtask

        // four-phase source for one input, lines of the test taken in file order
        task automatic run_source(input int p, input int first, input int last);
                @(negedge clk);
                for (int k = first; k <= last; k++) begin
                        if (t_in[k] == p) begin
                                dest[p*CW +: CW]         = noc_pkg::port_code_t'(t_dest[k]);
                                flit[p*FLIT_W +: FLIT_W] = t_flit[k];
                                req[p]                   = 1'b1;
                                do @(negedge clk); while (ack[p] !== 1'b1);
                                req[p] = 1'b0;
                                do @(negedge clk); while (ack[p] !== 1'b0);
                        end
                end
        endtask

        // longest stall asked for on each output, negative draws a random one
        task automatic hold_credit(input int first, input int last);
                int hold [NP];
                int h;
                int longest;
                longest = 0;
                for (int p = 0; p < NP; p++) begin
                        hold[p] = 0;
                end
                for (int k = first; k <= last; k++) begin
                        h = t_hold[k];
                        if (h < 0) begin
                                h = 2 + (next_rand() % 6);
                        end
                        if (h > hold[t_dest[k]]) begin
                                hold[t_dest[k]] = h;
                        end
                        if (h > longest) begin
                                longest = h;
                        end
                end
                @(negedge clk);
                for (int p = 0; p < NP; p++) begin
                        if (hold[p] > 0) begin
                                credit[p] = 1'b0;
                        end
                end
                for (int c = 1; c <= longest; c++) begin
                        @(negedge clk);
                        for (int p = 0; p < NP; p++) begin
                                if (hold[p] == c) begin
                                        credit[p] = 1'b1;
                                end
                        end
                end
        endtask

        initial begin
                int first;
                int last;
                req     = '0;
                dest    = '0;
                flit    = '0;
                credit  = '1;
                reset_i = 1'b1;
                load_vectors();
                cycle_limit = 20 * t_id.size() + 100;
                repeat (4) @(negedge clk);
                reset_i = 1'b0;
                first   = 0;
                // consecutive lines with one id form a test
                while (first < t_id.size()) begin
                        last = first;
                        while (last + 1 < t_id.size() && t_id[last+1] == t_id[first]) begin
                                last++;
                        end
                        for (int k = first; k <= last; k++) begin
                                chk0.expect_flit(t_in[k], t_exp[k], t_flit[k]);
                        end
                        fork
                                run_source(0, first, last);
                                run_source(1, first, last);
                                run_source(2, first, last);
                                run_source(3, first, last);
                                run_source(4, first, last);
                                hold_credit(first, last);
                        join
                        chk0.end_test(t_id[first]);
                        first = last + 1;
                end
                repeat (2) @(negedge clk);
                chk0.report_counts();
                if (vectors_ok && chk0.total_errors == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

        // watchdog sized from the number of transactions
        initial begin
                wait (cycle_limit > 0);
                while (cycles < cycle_limit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout, the run did not finish within %0d clock cycles", cycles);
                $display("tests failed");
                $finish;
        end

endmodule

//--- xbar_switch.f
src/noc_pkg.sv
src/route_decode.sv
src/rr_arbiter.sv
src/grant_result.sv
src/xbar_switch.sv
verif/xbar_switch_sva.sv
verif/xbar_switch_checker.sv
verif/xbar_switch_tb.sv

//--- Makefile
# Verilator build and run of the crossbar switch testbench

VERILATOR ?= verilator
TOP       ?= xbar_switch_tb
FILELIST  ?= xbar_switch.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# the run counts as passed only if the log holds the pass line
sim:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/xbar_switch_input.txt
# test input dest flit(hex) expected_output credit_hold_cycles
# ports 0 north 1 south 2 west 3 east 4 local, a hold of -1 asks for a random stall
1 0 4 a001 4 0
1 1 4 a002 4 0
1 2 4 a003 4 0
1 3 4 a004 4 0
2 0 1 b001 1 0
3 0 2 b002 2 0
4 0 3 b003 3 0
5 0 4 b004 4 0
6 1 0 b010 0 0
7 1 2 b012 2 0
8 1 3 b013 3 0
9 1 4 b014 4 0
10 2 0 b020 0 0
11 2 1 b021 1 0
12 2 3 b023 3 0
13 2 4 b024 4 0
14 3 0 b030 0 0
15 3 1 b031 1 0
16 3 2 b032 2 0
17 3 4 b034 4 0
18 4 0 b040 0 0
19 4 1 b041 1 0
20 4 2 b042 2 0
21 4 3 b043 3 0
22 0 2 c000 2 0
22 1 2 c010 2 0
22 3 2 c030 2 0
22 4 2 c040 2 0
22 0 2 c001 2 0
22 1 2 c011 2 0
22 3 2 c031 2 0
22 4 2 c041 2 0
23 0 1 d001 1 0
23 1 2 d012 2 0
23 2 3 d023 3 0
23 3 4 d034 4 0
23 4 0 d040 0 0
24 0 3 e000 3 12
24 1 3 e010 3 0
24 4 3 e040 3 0
25 1 0 f010 0 -1
25 4 0 f040 0 0
25 3 2 f032 2 -1
26 0 3 1230 3 0
26 0 3 4560 3 0
26 0 3 789a 3 0
26 4 1 5a5a 1 0
26 4 1 a5a5 1 0
